// File: src/DecodeTypes.sv
`default_nettype none

package DecodeTypes;

    localparam int BufferDepth = 8;                       // Parcel slots, also the initial fetch credits
    localparam int PtrWidth = $clog2(BufferDepth);
    localparam int CountWidth = $clog2(BufferDepth) + 1;  // Holds 0 to BufferDepth
    localparam int CreditWidth = 2;
    localparam int MaxCreditReturn = 2;                   // Credits handed back per cycle at most

    localparam logic [3:0] ExceptionIllegalInsn = 4'd2;
    localparam logic [3:0] ExceptionInsnPageFault = 4'd12;

    typedef enum logic [3:0] {
        AluReg,
        AluImm,
        Load,
        Store,
        Branch,
        Jal,
        Jalr,
        Lui,
        Auipc,
        System,
        Unknown
    } OpClass;

    // RV32I major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OpcodeLoad    = 7'b0000011,
        OpcodeMiscMem = 7'b0001111,
        OpcodeOpImm   = 7'b0010011,
        OpcodeAuipc   = 7'b0010111,
        OpcodeStore   = 7'b0100011,
        OpcodeOp      = 7'b0110011,
        OpcodeLui     = 7'b0110111,
        OpcodeBranch  = 7'b1100011,
        OpcodeJalr    = 7'b1100111,
        OpcodeJal     = 7'b1101111,
        OpcodeSystem  = 7'b1110011
    } Opcode;

    // Supported RV32C forms, keyed by {funct3, quadrant}
    typedef enum logic [4:0] {
        CLw    = 5'b010_00,
        CSw    = 5'b110_00,
        CAddi  = 5'b000_01,
        CLi    = 5'b010_01,
        CJ     = 5'b101_01,
        CMvAdd = 5'b100_10  // Bit 12 picks C.ADD over C.MV
    } CompressedOpcode;

    typedef struct packed {
        logic [31:0] address;
        logic [15:0] halfword;
        logic        fault;           // Fetch saw a page fault on this halfword
        logic        interruptValid;
        logic [3:0]  interruptCode;
    } Parcel;

    typedef struct packed {
        OpClass      opClass;
        logic [2:0]  funct3;
        logic        altFunct;        // Set for SUB and SRA/SRAI
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;             // Already sign-extended
    } Op;

    typedef struct packed {
        logic        valid;
        logic        isInterrupt;
        logic [3:0]  code;
        logic [31:0] value;
    } TrapInfo;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] insn;
        logic        isCompressed;
        Op           op;
        logic [11:0] csrAddr;
        TrapInfo     trapInfo;
    } DecodedInsn;

endpackage

`default_nettype wire

// File: src/InsnBuffer.sv
`default_nettype none

module InsnBuffer import DecodeTypes::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   push,
    input  Parcel                  pushParcel,
    input  logic                   readLow,
    input  logic                   readHigh,
    output Parcel                  readLowParcel,
    output Parcel                  readHighParcel,
    output logic [CountWidth-1:0]  readableCount,
    output logic [CreditWidth-1:0] creditReturn
);

    Parcel entries [BufferDepth];

    logic [PtrWidth-1:0]    readPtr;
    logic [PtrWidth-1:0]    highPtr;
    logic [PtrWidth-1:0]    writePtr;
    logic [CountWidth-1:0]  count;
    logic [CountWidth-1:0]  owedCredits;   // Credits earned but not yet returned
    logic [CreditWidth-1:0] popCount;
    logic [CountWidth-1:0]  totalCredits;
    logic [CountWidth-1:0]  retained;      // Entries left after this cycle's pops

    always_comb begin
        highPtr = readPtr + 1'b1;          // Wraps with the pointer width
        readLowParcel = entries[readPtr];
        readHighParcel = entries[highPtr];
        readableCount = count;
    end

    // Popped parcels pay back at once, anything above the per-cycle limit waits
    always_comb begin
        popCount = CreditWidth'(readLow) + CreditWidth'(readHigh);
        totalCredits = owedCredits + CountWidth'(popCount);
        retained = count - CountWidth'(popCount);
        if (totalCredits > CountWidth'(MaxCreditReturn)) begin
            creditReturn = CreditWidth'(MaxCreditReturn);
        end else begin
            creditReturn = CreditWidth'(totalCredits);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[writePtr] <= pushParcel;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
            owedCredits <= '0;
        end else if (flush) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
            // Every discarded parcel, a same-cycle push included, is still owed to fetch
            owedCredits <= totalCredits - CountWidth'(creditReturn) + retained
                           + CountWidth'(push);
        end else begin
            readPtr <= readPtr + PtrWidth'(popCount);
            writePtr <= writePtr + PtrWidth'(push);
            count <= retained + CountWidth'(push);
            owedCredits <= totalCredits - CountWidth'(creditReturn);
        end
    end

    // Fetch must hold a credit for every push, so a full buffer never sees one
    assert property (@(posedge clk) disable iff (reset)
        push |-> count < CountWidth'(BufferDepth))
        else $error("Parcel pushed into a full buffer");

    assert property (@(posedge clk) disable iff (reset)
        readHigh |-> readLow)
        else $error("High parcel read without the low parcel");

endmodule

`default_nettype wire

// File: src/Rv32Decoder.sv
`default_nettype none

module Rv32Decoder import DecodeTypes::*; (
    input  logic [31:0] insn,
    output Op           op
);

    Opcode       opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic        legal;
    logic        useRd;
    logic        useRs1;
    logic        useRs2;

    always_comb begin
        opcode = Opcode'(insn[6:0]);
        funct3 = insn[14:12];
        funct7 = insn[31:25];
        immI = {{20{insn[31]}}, insn[31:20]};
        immS = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        immB = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        immU = {insn[31:12], 12'b0};
        immJ = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end

    always_comb begin
        op = '0;
        op.funct3 = funct3;
        op.rd = insn[11:7];
        op.rs1 = insn[19:15];
        op.rs2 = insn[24:20];
        legal = 1'b1;
        useRd = 1'b1;
        useRs1 = 1'b1;
        useRs2 = 1'b0;
        case (opcode)
            OpcodeOp: begin
                op.opClass = AluReg;
                op.altFunct = insn[30];
                useRs2 = 1'b1;
                legal = funct7 == 7'b0 ||
                        (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101});
            end
            OpcodeOpImm: begin
                op.opClass = AluImm;
                op.imm = immI;
                if (funct3 inside {3'b001, 3'b101}) begin
                    op.imm = {27'b0, insn[24:20]};  // Shift amount only
                    op.altFunct = insn[30];
                    legal = funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b101);
                end
            end
            OpcodeLoad: begin
                op.opClass = Load;
                op.imm = immI;
                legal = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            OpcodeStore: begin
                op.opClass = Store;
                op.imm = immS;
                useRd = 1'b0;
                useRs2 = 1'b1;
                legal = funct3 inside {3'b000, 3'b001, 3'b010};
            end
            OpcodeBranch: begin
                op.opClass = Branch;
                op.imm = immB;
                useRd = 1'b0;
                useRs2 = 1'b1;
                legal = !(funct3 inside {3'b010, 3'b011});
            end
            OpcodeJal: begin
                op.opClass = Jal;
                op.funct3 = '0;
                op.imm = immJ;
                useRs1 = 1'b0;
            end
            OpcodeJalr: begin
                op.opClass = Jalr;
                op.imm = immI;
                legal = funct3 == 3'b000;
            end
            OpcodeLui, OpcodeAuipc: begin
                op.opClass = (opcode == OpcodeLui) ? Lui : Auipc;
                op.funct3 = '0;
                op.imm = immU;
                useRs1 = 1'b0;
            end
            OpcodeMiscMem, OpcodeSystem: begin
                op.opClass = System;  // FENCE travels as a system op with funct3 0
                op.imm = immI;
                legal = (opcode == OpcodeSystem) ? funct3 != 3'b100 : funct3 == 3'b000;
            end
            default: legal = 1'b0;
        endcase
        // Fields the format does not carry read as zero
        if (!useRd) begin
            op.rd = '0;
        end
        if (!useRs1) begin
            op.rs1 = '0;
        end
        if (!useRs2) begin
            op.rs2 = '0;
        end
        if (!legal) begin
            op = '0;
            op.opClass = Unknown;
        end
    end

endmodule

`default_nettype wire

// File: src/CompressedDecoder.sv
`default_nettype none

module CompressedDecoder import DecodeTypes::*; (
    input  logic [15:0] parcel,
    output Op           op
);

    CompressedOpcode cOpcode;
    logic [4:0]      rdFull;
    logic [4:0]      rs2Full;
    logic [4:0]      rdPrime;
    logic [4:0]      rs1Prime;
    logic [31:0]     immCi;
    logic [31:0]     offsetCl;
    logic [31:0]     offsetCj;

    always_comb begin
        cOpcode = CompressedOpcode'({parcel[15:13], parcel[1:0]});
        rdFull = parcel[11:7];
        rs2Full = parcel[6:2];
        // Three-bit register fields reach only x8 to x15
        rdPrime = {2'b01, parcel[4:2]};
        rs1Prime = {2'b01, parcel[9:7]};
        immCi = {{27{parcel[12]}}, parcel[6:2]};
        offsetCl = {25'b0, parcel[5], parcel[12:10], parcel[6], 2'b00};  // Word scaled, unsigned
        // C.J keeps offset bits 11, 4, 9:8, 10, 6, 7, 3:1, 5 in parcel bits 12 to 2
        offsetCj = {{20{parcel[12]}}, parcel[12], parcel[8], parcel[10:9], parcel[6],
                    parcel[7], parcel[2], parcel[11], parcel[5:3], 1'b0};
    end

    always_comb begin
        op = '0;
        op.opClass = Unknown;
        case (cOpcode)
            CAddi: begin
                op.opClass = AluImm;      // C.NOP is the rd = 0, imm = 0 case
                op.rd = rdFull;
                op.rs1 = rdFull;
                op.imm = immCi;
            end
            CLi: begin
                op.opClass = AluImm;      // ADDI rd, x0, imm
                op.rd = rdFull;
                op.imm = immCi;
            end
            CLw: begin
                op.opClass = Load;
                op.funct3 = 3'b010;
                op.rd = rdPrime;
                op.rs1 = rs1Prime;
                op.imm = offsetCl;
            end
            CSw: begin
                op.opClass = Store;
                op.funct3 = 3'b010;
                op.rs1 = rs1Prime;
                op.rs2 = rdPrime;         // Source register sits where C.LW has rd'
                op.imm = offsetCl;
            end
            CJ: begin
                op.opClass = Jal;         // JAL x0, offset
                op.imm = offsetCj;
            end
            CMvAdd: begin
                // With rs2 = 0 these are C.JR and C.JALR, which stay unsupported
                if (rs2Full != 5'd0) begin
                    op.opClass = AluReg;
                    op.rd = rdFull;
                    op.rs1 = parcel[12] ? rdFull : 5'd0;
                    op.rs2 = rs2Full;
                end
            end
            default: op.opClass = Unknown;
        endcase
    end

endmodule

`default_nettype wire

// File: src/DecodeStage.sv
`default_nettype none

module DecodeStage import DecodeTypes::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  Parcel                 readLowParcel,
    input  Parcel                 readHighParcel,
    input  logic [CountWidth-1:0] readableCount,
    input  Op                     fullOp,
    input  Op                     compressedOp,
    output logic [31:0]           insn,
    output logic                  readLow,
    output logic                  readHigh,
    output DecodedInsn            decoded
);

    logic       isCompressed;
    logic       valid;
    Op          op;
    TrapInfo    trapInfo;
    DecodedInsn nextInsn;

    always_comb begin
        isCompressed = readLowParcel.halfword[1:0] != 2'b11;
        valid = (readableCount == CountWidth'(1) && isCompressed) ||
                readableCount >= CountWidth'(2);
        insn = isCompressed ? {16'h0, readLowParcel.halfword}
                            : {readHighParcel.halfword, readLowParcel.halfword};
        op = isCompressed ? compressedOp : fullOp;
    end

    // Interrupts first, then fetch faults, then illegal encodings
    always_comb begin
        trapInfo = '0;
        if (valid) begin
            if (readLowParcel.interruptValid) begin
                trapInfo.valid = 1'b1;
                trapInfo.isInterrupt = 1'b1;
                trapInfo.code = readLowParcel.interruptCode;
                trapInfo.value = readLowParcel.address;
            end else if (!isCompressed && readHighParcel.interruptValid) begin
                trapInfo.valid = 1'b1;
                trapInfo.isInterrupt = 1'b1;
                trapInfo.code = readHighParcel.interruptCode;
                trapInfo.value = readLowParcel.address;
            end else if (readLowParcel.fault || (!isCompressed && readHighParcel.fault)) begin
                trapInfo.valid = 1'b1;
                trapInfo.code = ExceptionInsnPageFault;
                trapInfo.value = readLowParcel.address;
            end else if (op.opClass == Unknown) begin
                trapInfo.valid = 1'b1;
                trapInfo.code = ExceptionIllegalInsn;
                trapInfo.value = insn;
            end
        end
    end

    always_comb begin
        readLow = valid && !stall;
        readHigh = valid && !isCompressed && !stall;
        nextInsn.valid = 1'b1;
        nextInsn.pc = readLowParcel.address;
        nextInsn.insn = insn;
        nextInsn.isCompressed = isCompressed;
        nextInsn.op = op;
        nextInsn.csrAddr = insn[31:20];
        nextInsn.trapInfo = trapInfo;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            decoded <= '0;
        end else if (!stall) begin
            decoded <= valid ? nextInsn : '0;  // Bubble when no full instruction is buffered
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        stall && !flush |=> $stable(decoded))
        else $error("Decoded record changed while stalled");

endmodule

`default_nettype wire

// File: src/DecodeFrontEnd.sv
`default_nettype none

module DecodeFrontEnd import DecodeTypes::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   push,
    input  Parcel                  pushParcel,
    output logic [CreditWidth-1:0] creditReturn,
    output DecodedInsn             decoded
);

    Parcel                 readLowParcel;
    Parcel                 readHighParcel;
    logic [CountWidth-1:0] readableCount;
    logic                  readLow;
    logic                  readHigh;
    logic [31:0]           insn;
    Op                     fullOp;
    Op                     compressedOp;

    InsnBuffer i_insnBuffer (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .push           (push),
        .pushParcel     (pushParcel),
        .readLow        (readLow),
        .readHigh       (readHigh),
        .readLowParcel  (readLowParcel),
        .readHighParcel (readHighParcel),
        .readableCount  (readableCount),
        .creditReturn   (creditReturn)
    );

    Rv32Decoder i_rv32Decoder (
        .insn (insn),
        .op   (fullOp)
    );

    CompressedDecoder i_compressedDecoder (
        .parcel (readLowParcel.halfword),  // Only the oldest parcel can be compressed
        .op     (compressedOp)
    );

    DecodeStage i_decodeStage (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .readLowParcel  (readLowParcel),
        .readHighParcel (readHighParcel),
        .readableCount  (readableCount),
        .fullOp         (fullOp),
        .compressedOp   (compressedOp),
        .insn           (insn),
        .readLow        (readLow),
        .readHigh       (readHigh),
        .decoded        (decoded)
    );

endmodule

`default_nettype wire

// File: tb/DecodeFrontEndTb.sv
`default_nettype none

module DecodeFrontEndTb import DecodeTypes::*; ();

    localparam int RecordWidth = 153;     // pc, insn, isCompressed, opClass, rd, rs1, rs2, imm, trap

    typedef logic [RecordWidth-1:0] Record;
    typedef logic [16:0] Extra;           // isInterrupt, csrAddr, funct3, altFunct

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   flush;
    logic                   push;
    Parcel                  pushParcel;
    logic [CreditWidth-1:0] creditReturn;
    DecodedInsn             decoded;

    byte   entryKind[$];                  // One entry per pattern line, T, P, E or F
    Parcel entryParcel[$];
    Record entryRecord[$];
    string testNames[$];
    Record expected[$];                   // Records still owed by the DUT for the running test
    Extra  expectedExtra[$];
    logic  interruptAt[logic [31:0]];     // Interrupt flag of each parcel address in the test
    string testName = "none";
    int    creditCount = BufferDepth;
    int    errorCount = 0;
    int    cycleCount = 0;
    int    cycleLimit = 200;
    logic  checking = 1'b0;
    logic  stallAtEdge = 1'b0;

    DecodeFrontEnd i_dut (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .push         (push),
        .pushParcel   (pushParcel),
        .creditReturn (creditReturn),
        .decoded      (decoded)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic loadPatterns(output int parcelCount);
        int          fd;
        int          fields;
        int          wanted;
        string       line;
        string       name;
        Parcel       parcel;
        Record       record;
        logic [31:0] address;
        logic [31:0] insnWord;
        logic [31:0] imm;
        logic [31:0] trapValue;
        logic [15:0] halfword;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  opClass;
        logic [3:0]  code;
        logic        flagA;
        logic        flagB;
        parcelCount = 0;
        fd = $fopen("tb/decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tb/decode_patterns.txt");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                 // Blank lines and column notes
            end
            parcel = '0;
            record = '0;
            fields = 0;
            wanted = 0;
            case (line[0])
                "T": begin
                    wanted = 1;
                    fields = $sscanf(line, "T %s", name);
                    testNames.push_back(name);
                end
                "P": begin
                    wanted = 5;
                    fields = $sscanf(line, "P %h %h %h %h %h",
                                     address, halfword, flagA, flagB, code);
                    parcel = {address, halfword, flagA, flagB, code};
                    parcelCount++;
                end
                "E": begin
                    wanted = 11;
                    fields = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h",
                                     address, insnWord, flagA, opClass, rd, rs1, rs2,
                                     imm, flagB, code, trapValue);
                    record = {address, insnWord, flagA, opClass, rd, rs1, rs2,
                              imm, flagB, code, trapValue};
                end
                "F": wanted = 0;
                default: wanted = -1;
            endcase
            assert (fields == wanted) else begin
                $display("Pattern line could not be read: %s", line);
                errorCount++;
            end
            entryKind.push_back(line[0]);
            entryParcel.push_back(parcel);
            entryRecord.push_back(record);
        end
        $fclose(fd);
    endtask

    // Fields the pattern file does not list follow from the encoding rules
    function automatic Extra deriveExtra(input Record r, input logic isInterrupt);
        logic [31:0] insnWord;
        logic        compressed;
        logic [3:0]  opClass;
        logic [2:0]  funct3;
        logic        altFunct;
        insnWord = r[120:89];
        compressed = r[88];
        opClass = r[87:84];
        funct3 = insnWord[14:12];
        altFunct = insnWord[30] &&
                   (opClass == AluReg || (opClass == AluImm && funct3 == 3'b101));
        if (compressed) begin
            funct3 = (opClass == Load || opClass == Store) ? 3'b010 : 3'b000;
            altFunct = 1'b0;
        end else if (opClass == Jal || opClass == Lui || opClass == Auipc ||
                     opClass == Unknown) begin
            funct3 = 3'b000;
        end
        return {isInterrupt, insnWord[31:20], funct3, altFunct};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
        stall = ($urandom % 4) == 0;      // Roughly one cycle in four
    endtask

    task automatic sendParcel(input Parcel parcel);
        while (creditCount == 0) begin
            push = 1'b0;
            nextCycle();
        end
        push = 1'b1;
        pushParcel = parcel;
        creditCount--;
        assert (creditCount >= 0) else begin
            $display("Credit counter went negative in test %s", testName);
            errorCount++;
        end
        nextCycle();
        push = 1'b0;
    endtask

    task automatic applyFlush();
        push = 1'b0;
        flush = 1'b1;
        nextCycle();
        flush = 1'b0;
        checking = 1'b1;                  // Only records of later parcels may follow
    endtask

    task automatic drainTest();
        int waited;
        while (expected.size() > 0) begin
            nextCycle();
        end
        waited = 0;
        while (creditCount != BufferDepth && waited < 8) begin
            nextCycle();                  // Flushed credits come back two per cycle at most
            waited++;
        end
        assert (creditCount == BufferDepth) else begin
            $display("MISMATCH %s credits expected %0d actual %0d",
                     testName, BufferDepth, creditCount);
            errorCount++;
        end
    endtask

    task automatic checkRecord();
        Record actual;
        Record wanted;
        Extra  actualExtra;
        Extra  wantedExtra;
        actual = {decoded.pc, decoded.insn, decoded.isCompressed, decoded.op.opClass,
                  decoded.op.rd, decoded.op.rs1, decoded.op.rs2, decoded.op.imm,
                  decoded.trapInfo.valid, decoded.trapInfo.code, decoded.trapInfo.value};
        actualExtra = {decoded.trapInfo.isInterrupt, decoded.csrAddr, decoded.op.funct3,
                       decoded.op.altFunct};
        assert (expected.size() > 0) else begin
            $display("Test %s produced an unexpected record at pc %h", testName, decoded.pc);
            errorCount++;
        end
        if (expected.size() > 0) begin
            wanted = expected.pop_front();
            wantedExtra = expectedExtra.pop_front();
            assert (actual == wanted) else begin
                $display("MISMATCH %s expected %h actual %h", testName, wanted, actual);
                errorCount++;
            end
            assert (actualExtra == wantedExtra) else begin
                $display("MISMATCH %s extra fields expected %h actual %h",
                         testName, wantedExtra, actualExtra);
                errorCount++;
            end
        end
    endtask

    // Mid-cycle sampling sees the settled outputs of the last edge
    always @(negedge clk) begin
        if (!reset) begin
            creditCount += int'(creditReturn);
            assert (creditCount <= BufferDepth) else begin
                $display("Credit counter rose above the buffer depth in test %s", testName);
                errorCount++;
            end
            if (checking && decoded.valid && !stallAtEdge) begin
                checkRecord();
            end
            stallAtEdge = stall;          // Stall holds until the coming edge
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles with %0d records still awaited",
                     cycleCount, expected.size());
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int          parcelCount;
        int          idx;
        int          last;
        int          testCount;
        int          failedTests;
        int          errorsAtStart;
        logic [31:0] pc;
        logic        lowInterrupt;
        logic        highInterrupt;
        void'($urandom(42406));
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        push = 1'b0;
        pushParcel = '0;
        testCount = 0;
        failedTests = 0;
        loadPatterns(parcelCount);
        cycleLimit = 20 * parcelCount + 200;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        idx = 0;
        while (idx < entryKind.size()) begin
            if (entryKind[idx] != "T") begin
                idx++;
                continue;
            end
            testName = testNames[testCount];
            testCount++;
            errorsAtStart = errorCount;
            checking = 1'b1;
            interruptAt.delete();
            last = idx + 1;
            while (last < entryKind.size() && entryKind[last] != "T") begin
                if (entryKind[last] == "P") begin
                    interruptAt[entryParcel[last].address] = entryParcel[last].interruptValid;
                end
                if (entryKind[last] == "E") begin
                    pc = entryRecord[last][152:121];
                    lowInterrupt = interruptAt.exists(pc) ? interruptAt[pc] : 1'b0;
                    highInterrupt = interruptAt.exists(pc + 2) ? interruptAt[pc + 2] : 1'b0;
                    expected.push_back(entryRecord[last]);
                    expectedExtra.push_back(deriveExtra(entryRecord[last],
                        lowInterrupt || (!entryRecord[last][88] && highInterrupt)));
                end
                if (entryKind[last] == "F") begin
                    checking = 1'b0;      // Output before the flush is not judged
                end
                last++;
            end
            for (int j = idx + 1; j < last; j++) begin
                if (entryKind[j] == "P") begin
                    sendParcel(entryParcel[j]);
                end else if (entryKind[j] == "F") begin
                    applyFlush();
                end
            end
            drainTest();
            $display("Test %s finished with %0d errors", testName, errorCount - errorsAtStart);
            if (errorCount != errorsAtStart) begin
                failedTests++;
            end
            idx = last;
        end
        stall = 1'b0;
        $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0 && testCount > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/decode_patterns.txt
# T name | P address halfword fault interruptValid interruptCode | F flush here
# E pc insn isCompressed opClass rd rs1 rs2 imm trapValid trapCode trapValue, all hex
# opClass 0 AluReg 1 AluImm 2 Load 3 Store 4 Branch 5 Jal 7 Lui a Unknown
T rv32i_mix
P 00001000 0093 0 0 0
P 00001002 ffb0 0 0 0
P 00001004 81b3 0 0 0
P 00001006 4020 0 0 0
P 00001008 a623 0 0 0
P 0000100a 0063 0 0 0
P 0000100c 8ee3 0 0 0
P 0000100e fe20 0 0 0
E 00001000 ffb00093 0 1 01 00 00 fffffffb 0 0 00000000
E 00001004 402081b3 0 0 03 01 02 00000000 0 0 00000000
E 00001008 0063a623 0 3 00 07 06 0000000c 0 0 00000000
E 0000100c fe208ee3 0 4 00 01 02 fffffffc 0 0 00000000
T trap_priority
P 00002000 0093 1 0 0
P 00002002 ffb0 0 1 7
P 00002004 0000 1 0 0
P 00002006 0000 0 0 0
P 00002008 507b 0 0 0
P 0000200a 1234 0 0 0
P 0000200c 1475 1 1 3
E 00002000 ffb00093 0 1 01 00 00 fffffffb 1 7 00002000
E 00002004 00000000 1 a 00 00 00 00000000 1 c 00002004
E 00002006 00000000 1 a 00 00 00 00000000 1 2 00000000
E 00002008 1234507b 0 a 00 00 00 00000000 1 2 1234507b
E 0000200c 00001475 1 1 08 08 00 fffffffd 1 3 0000200c
T flush_mid
P 00003000 0093 0 0 0
P 00003002 ffb0 0 0 0
P 00003004 52b7 0 0 0
F
T compressed
P 00000100 1475 0 0 0
P 00000102 e2b7 0 0 0
P 00000104 abcd 0 0 0
P 00000106 4144 0 0 0
P 00000108 c40c 0 0 0
P 0000010a bff5 0 0 0
P 0000010c 9636 0 0 0
P 0000010e 477d 0 0 0
P 00000110 8786 0 0 0
E 00000100 00001475 1 1 08 08 00 fffffffd 0 0 00000000
E 00000102 abcde2b7 0 7 05 00 00 abcde000 0 0 00000000
E 00000106 00004144 1 2 09 0a 00 00000004 0 0 00000000
E 00000108 0000c40c 1 3 00 08 0b 00000008 0 0 00000000
E 0000010a 0000bff5 1 5 00 00 00 fffffffc 0 0 00000000
E 0000010c 00009636 1 0 0c 0c 0d 00000000 0 0 00000000
E 0000010e 0000477d 1 1 0e 00 00 0000001f 0 0 00000000
E 00000110 00008786 1 0 0f 00 01 00000000 0 0 00000000

// File: project.f
src/DecodeTypes.sv
src/InsnBuffer.sv
src/Rv32Decoder.sv
src/CompressedDecoder.sv
src/DecodeStage.sv
src/DecodeFrontEnd.sv
tb/DecodeFrontEndTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= DecodeFrontEndTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
